//--- src/lumi_rx_settings.svh
/*
 * Link receiver settings
 * Widths of the PHY beat, the output word and the packet fields,
 * and the byte counts that frame a packet
 */

`ifndef LUMI_RX_SETTINGS_SVH
`define LUMI_RX_SETTINGS_SVH

// Bus and field widths in bits
`define LUMI_IOW        64
`define LUMI_DW         256
`define LUMI_CW         32
`define LUMI_AW         64

// Packet framing in bytes
`define LUMI_HDR_BYTES  20      // cmd + dstaddr + srcaddr
`define LUMI_CMD_BYTES  4       // Link and invalid packets
`define LUMI_DATA_BYTES 32      // Max payload fills one output word

// Byte offset counter
`define LUMI_CNT_W      6

`endif

//--- src/lumi_rx_pkg.sv
/*
 * Link receiver package
 * Opcode and state encodings, routing destination and the
 * packet field types shared by the receiver blocks
 */

`include "lumi_rx_settings.svh"

package lumi_rx_pkg;

    //##################################################
    // Encodings
    //##################################################

    typedef enum logic [4:0] {
        OP_INVALID    = 5'd0,
        OP_REQ_READ   = 5'd1,
        OP_RESP_READ  = 5'd2,
        OP_REQ_WRITE  = 5'd3,
        OP_RESP_WRITE = 5'd4,
        OP_REQ_POSTED = 5'd5,
        OP_REQ_ATOMIC = 5'd9,
        OP_LINK       = 5'd15
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,        // Waiting for first beat
        ST_RECV,        // Collecting remaining beats
        ST_DELIVER      // Holding packet on output port
    } rx_state_e;

    typedef enum logic [1:0] {
        DEST_REQ,
        DEST_RESP,
        DEST_DROP
    } pkt_dest_e;

    //##################################################
    // Field types
    //##################################################

    // Low bits of the command word carry the decode fields
    typedef struct packed {
        logic [`LUMI_CW-17:0] upper;    // Passed through untouched
        logic [7:0]           len;
        logic [2:0]           size;
        logic [4:0]           opcode;
    } cmd_t;

    typedef logic [`LUMI_AW-1:0]    addr_t;
    typedef logic [`LUMI_DW-1:0]    data_t;
    typedef logic [`LUMI_IOW-1:0]   beat_t;
    typedef logic [`LUMI_CNT_W-1:0] byte_cnt_t;

    // Bytes per beat is 2**code for legal codes 1 to 3
    typedef logic [7:0]             iowidth_t;

endpackage

//--- src/rx_header_decode.sv
/*
 * Header decode
 * Classifies a packet from the command in its first beat and
 * provides total length, payload length and output destination
 */

`timescale 1ns/1ps

`include "lumi_rx_settings.svh"

module rx_header_decode (
    input  logic                   ioclk,
    input  logic                   ionreset,
    input  logic                   first_beat,
    input  logic                   beat_take,
    input  lumi_rx_pkg::beat_t     phy_rxdata,
    output lumi_rx_pkg::byte_cnt_t pkt_bytes,
    output lumi_rx_pkg::byte_cnt_t payload_bytes,
    output lumi_rx_pkg::pkt_dest_e pkt_dest
);

    lumi_rx_pkg::cmd_t      hdr;
    lumi_rx_pkg::opcode_e   opcode;
    logic [15:0]            len_p1;
    logic [15:0]            len_bytes;
    lumi_rx_pkg::byte_cnt_t data_bytes;     // Clamped payload length
    lumi_rx_pkg::byte_cnt_t live_bytes;
    lumi_rx_pkg::byte_cnt_t live_payload;
    lumi_rx_pkg::pkt_dest_e live_dest;
    lumi_rx_pkg::byte_cnt_t held_bytes;
    lumi_rx_pkg::byte_cnt_t held_payload;
    lumi_rx_pkg::pkt_dest_e held_dest;

    // Only the low 16 bits are guaranteed in the first beat
    assign hdr    = lumi_rx_pkg::cmd_t'({{(`LUMI_CW-16){1'b0}}, phy_rxdata[15:0]});
    assign opcode = lumi_rx_pkg::opcode_e'(hdr.opcode);

    assign len_p1    = {8'h00, hdr.len} + 16'd1;
    assign len_bytes = len_p1 << hdr.size;
    assign data_bytes = (len_bytes > 16'(`LUMI_DATA_BYTES)) ?
                        lumi_rx_pkg::byte_cnt_t'(`LUMI_DATA_BYTES) :
                        len_bytes[`LUMI_CNT_W-1:0];

    //##################################################
    // Packet format
    //##################################################
    always_comb begin
        case (opcode)
            lumi_rx_pkg::OP_REQ_READ,
            lumi_rx_pkg::OP_RESP_WRITE: begin    // Metadata only
                live_bytes   = lumi_rx_pkg::byte_cnt_t'(`LUMI_HDR_BYTES);
                live_payload = '0;
            end
            lumi_rx_pkg::OP_RESP_READ,
            lumi_rx_pkg::OP_REQ_WRITE,
            lumi_rx_pkg::OP_REQ_POSTED,
            lumi_rx_pkg::OP_REQ_ATOMIC: begin
                live_bytes   = lumi_rx_pkg::byte_cnt_t'(`LUMI_HDR_BYTES) + data_bytes;
                live_payload = data_bytes;
            end
            default: begin   // Link, invalid and unknown opcodes
                live_bytes   = lumi_rx_pkg::byte_cnt_t'(`LUMI_CMD_BYTES);
                live_payload = '0;
            end
        endcase
    end

    // Routing follows request/response class
    always_comb begin
        case (opcode)
            lumi_rx_pkg::OP_REQ_READ,
            lumi_rx_pkg::OP_REQ_WRITE,
            lumi_rx_pkg::OP_REQ_POSTED,
            lumi_rx_pkg::OP_REQ_ATOMIC: live_dest = lumi_rx_pkg::DEST_REQ;
            lumi_rx_pkg::OP_RESP_READ,
            lumi_rx_pkg::OP_RESP_WRITE: live_dest = lumi_rx_pkg::DEST_RESP;
            default:                    live_dest = lumi_rx_pkg::DEST_DROP;
        endcase
    end

    // Hold decode for the rest of the packet
    always_ff @(posedge ioclk or negedge ionreset) begin
        if (!ionreset) begin
            held_bytes   <= '0;
            held_payload <= '0;
            held_dest    <= lumi_rx_pkg::DEST_DROP;
        end else if (first_beat && beat_take) begin
            held_bytes   <= live_bytes;
            held_payload <= live_payload;
            held_dest    <= live_dest;
        end
    end

    assign pkt_bytes     = first_beat ? live_bytes : held_bytes;
    assign payload_bytes = first_beat ? live_payload : held_payload;
    assign pkt_dest      = first_beat ? live_dest : held_dest;

endmodule

//--- src/rx_packet_fsm.sv
/*
 * Packet FSM
 * Tracks beats of a packet, drives PHY ready and the
 * valid/ready handshake on the request and response ports
 */

`timescale 1ns/1ps

module rx_packet_fsm (
    input  logic                   ioclk,
    input  logic                   ionreset,
    input  logic                   csr_en,
    input  lumi_rx_pkg::iowidth_t  csr_iowidth,
    input  logic                   phy_rxvld,
    output logic                   phy_rxrdy,
    input  lumi_rx_pkg::byte_cnt_t pkt_bytes,
    input  lumi_rx_pkg::pkt_dest_e pkt_dest,
    input  logic                   req_ready,
    input  logic                   resp_ready,
    output logic                   req_valid,
    output logic                   resp_valid,
    output logic                   beat_take,
    output logic                   first_beat,
    output lumi_rx_pkg::byte_cnt_t byte_cnt
);

    lumi_rx_pkg::rx_state_e state;
    lumi_rx_pkg::rx_state_e state_next;
    lumi_rx_pkg::byte_cnt_t width_bytes;
    lumi_rx_pkg::byte_cnt_t cnt_after;
    logic                   rdy_armed;      // Low for one cycle out of reset
    logic                   last_beat;
    logic                   commit;

    assign width_bytes = lumi_rx_pkg::byte_cnt_t'(1) << csr_iowidth;
    assign cnt_after   = byte_cnt + width_bytes;
    assign last_beat   = (cnt_after >= pkt_bytes);

    //##################################################
    // Handshakes
    //##################################################
    assign phy_rxrdy  = rdy_armed & csr_en & (state != lumi_rx_pkg::ST_DELIVER);
    assign beat_take  = phy_rxvld & phy_rxrdy;
    assign first_beat = (state == lumi_rx_pkg::ST_IDLE);

    assign req_valid  = (state == lumi_rx_pkg::ST_DELIVER) &
                        (pkt_dest == lumi_rx_pkg::DEST_REQ);
    assign resp_valid = (state == lumi_rx_pkg::ST_DELIVER) &
                        (pkt_dest == lumi_rx_pkg::DEST_RESP);
    assign commit     = (req_valid & req_ready) | (resp_valid & resp_ready);

    //##################################################
    // State machine
    //##################################################
    always_comb begin
        state_next = state;
        case (state)
            lumi_rx_pkg::ST_IDLE,
            lumi_rx_pkg::ST_RECV: begin
                if (beat_take) begin
                    if (!last_beat)
                        state_next = lumi_rx_pkg::ST_RECV;
                    else if (pkt_dest == lumi_rx_pkg::DEST_DROP)
                        state_next = lumi_rx_pkg::ST_IDLE;    // Silent drop
                    else
                        state_next = lumi_rx_pkg::ST_DELIVER;
                end
            end
            lumi_rx_pkg::ST_DELIVER: begin
                if (commit)
                    state_next = lumi_rx_pkg::ST_IDLE;
            end
            default: state_next = lumi_rx_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge ioclk or negedge ionreset) begin
        if (!ionreset) begin
            state     <= lumi_rx_pkg::ST_IDLE;
            rdy_armed <= 1'b0;
        end else begin
            state     <= state_next;
            rdy_armed <= 1'b1;
        end
    end

    // Byte offset of the next beat returns to zero after the final one
    always_ff @(posedge ioclk or negedge ionreset) begin
        if (!ionreset)
            byte_cnt <= '0;
        else if (beat_take)
            byte_cnt <= last_beat ? '0 : cnt_after;
    end

endmodule

//--- src/rx_metadata_assembler.sv
/*
 * Metadata assembler
 * Gathers the first 20 packet bytes from the beat lanes and
 * splits them into command, destination and source address
 */

`timescale 1ns/1ps

`include "lumi_rx_settings.svh"

module rx_metadata_assembler (
    input  logic                   ioclk,
    input  logic                   ionreset,
    input  logic                   beat_take,
    input  logic                   first_beat,
    input  lumi_rx_pkg::iowidth_t  csr_iowidth,
    input  lumi_rx_pkg::byte_cnt_t byte_cnt,
    input  lumi_rx_pkg::beat_t     phy_rxdata,
    output lumi_rx_pkg::cmd_t      meta_cmd,
    output lumi_rx_pkg::addr_t     meta_dstaddr,
    output lumi_rx_pkg::addr_t     meta_srcaddr
);

    localparam int LANES = `LUMI_IOW / 8;

    logic [`LUMI_HDR_BYTES-1:0][7:0] meta_q;
    logic [`LUMI_HDR_BYTES-1:0][7:0] meta_next;
    int                              lane_cnt;

    assign lane_cnt = 1 << csr_iowidth;

    //##################################################
    // Lane to byte placement
    //##################################################
    always_comb begin
        int pos;
        meta_next = first_beat ? '0 : meta_q;   // Fresh packet starts clean
        for (int lane = 0; lane < LANES; lane++) begin
            pos = int'(byte_cnt) + lane;
            if (lane < lane_cnt && pos < `LUMI_HDR_BYTES)
                meta_next[pos] = phy_rxdata[lane*8 +: 8];
        end
    end

    always_ff @(posedge ioclk or negedge ionreset) begin
        if (!ionreset)
            meta_q <= '0;
        else if (beat_take)
            meta_q <= meta_next;
    end

    // Little-endian fields with byte 0 as the command LSB
    assign meta_cmd     = lumi_rx_pkg::cmd_t'(meta_q[3:0]);
    assign meta_dstaddr = lumi_rx_pkg::addr_t'(meta_q[11:4]);
    assign meta_srcaddr = lumi_rx_pkg::addr_t'(meta_q[19:12]);

endmodule

//--- src/rx_payload_assembler.sv
/*
 * Payload assembler
 * Places the payload bytes that follow the metadata into the
 * output data word and leaves unused bytes at zero
 */

`timescale 1ns/1ps

`include "lumi_rx_settings.svh"

module rx_payload_assembler (
    input  logic                   ioclk,
    input  logic                   ionreset,
    input  logic                   beat_take,
    input  logic                   first_beat,
    input  lumi_rx_pkg::iowidth_t  csr_iowidth,
    input  lumi_rx_pkg::byte_cnt_t byte_cnt,
    input  lumi_rx_pkg::byte_cnt_t payload_bytes,
    input  lumi_rx_pkg::beat_t     phy_rxdata,
    output lumi_rx_pkg::data_t     payload
);

    localparam int LANES = `LUMI_IOW / 8;

    logic [`LUMI_DATA_BYTES-1:0][7:0] data_q;
    logic [`LUMI_DATA_BYTES-1:0][7:0] data_next;
    int                               lane_cnt;
    int                               data_end;     // First byte past the payload

    assign lane_cnt = 1 << csr_iowidth;
    assign data_end = `LUMI_HDR_BYTES + int'(payload_bytes);

    //##################################################
    // Lane to byte placement
    //##################################################
    always_comb begin
        int pos;
        data_next = first_beat ? '0 : data_q;
        for (int lane = 0; lane < LANES; lane++) begin
            pos = int'(byte_cnt) + lane;
            // Metadata lanes and unused tail lanes fall outside
            if (lane < lane_cnt && pos >= `LUMI_HDR_BYTES && pos < data_end)
                data_next[pos - `LUMI_HDR_BYTES] = phy_rxdata[lane*8 +: 8];
        end
    end

    always_ff @(posedge ioclk or negedge ionreset) begin
        if (!ionreset)
            data_q <= '0;
        else if (beat_take)
            data_q <= data_next;
    end

    assign payload = lumi_rx_pkg::data_t'(data_q);

endmodule

//--- src/lumi_rx_top.sv
/*
 * Link packet receiver
 * Rebuilds packets from PHY beats and presents them on the
 * request or response port with valid/ready flow control
 */

`timescale 1ns/1ps

module lumi_rx_top (
    input  logic                  ioclk,
    input  logic                  ionreset,
    input  logic                  csr_en,
    input  lumi_rx_pkg::iowidth_t csr_iowidth,
    // PHY side
    input  lumi_rx_pkg::beat_t    phy_rxdata,
    input  logic                  phy_rxvld,
    output logic                  phy_rxrdy,
    // Request port
    output lumi_rx_pkg::cmd_t     req_cmd,
    output lumi_rx_pkg::addr_t    req_dstaddr,
    output lumi_rx_pkg::addr_t    req_srcaddr,
    output lumi_rx_pkg::data_t    req_data,
    output logic                  req_valid,
    input  logic                  req_ready,
    // Response port
    output lumi_rx_pkg::cmd_t     resp_cmd,
    output lumi_rx_pkg::addr_t    resp_dstaddr,
    output lumi_rx_pkg::addr_t    resp_srcaddr,
    output lumi_rx_pkg::data_t    resp_data,
    output logic                  resp_valid,
    input  logic                  resp_ready
);

    logic                   beat_take;
    logic                   first_beat;
    lumi_rx_pkg::byte_cnt_t byte_cnt;
    lumi_rx_pkg::byte_cnt_t pkt_bytes;
    lumi_rx_pkg::byte_cnt_t payload_bytes;
    lumi_rx_pkg::pkt_dest_e pkt_dest;
    lumi_rx_pkg::cmd_t      meta_cmd;
    lumi_rx_pkg::addr_t     meta_dstaddr;
    lumi_rx_pkg::addr_t     meta_srcaddr;
    lumi_rx_pkg::data_t     payload;

    rx_header_decode u_decode (
        .ioclk         (ioclk),
        .ionreset      (ionreset),
        .first_beat    (first_beat),
        .beat_take     (beat_take),
        .phy_rxdata    (phy_rxdata),
        .pkt_bytes     (pkt_bytes),
        .payload_bytes (payload_bytes),
        .pkt_dest      (pkt_dest)
    );

    rx_packet_fsm u_fsm (
        .ioclk       (ioclk),
        .ionreset    (ionreset),
        .csr_en      (csr_en),
        .csr_iowidth (csr_iowidth),
        .phy_rxvld   (phy_rxvld),
        .phy_rxrdy   (phy_rxrdy),
        .pkt_bytes   (pkt_bytes),
        .pkt_dest    (pkt_dest),
        .req_ready   (req_ready),
        .resp_ready  (resp_ready),
        .req_valid   (req_valid),
        .resp_valid  (resp_valid),
        .beat_take   (beat_take),
        .first_beat  (first_beat),
        .byte_cnt    (byte_cnt)
    );

    rx_metadata_assembler u_meta (
        .ioclk        (ioclk),
        .ionreset     (ionreset),
        .beat_take    (beat_take),
        .first_beat   (first_beat),
        .csr_iowidth  (csr_iowidth),
        .byte_cnt     (byte_cnt),
        .phy_rxdata   (phy_rxdata),
        .meta_cmd     (meta_cmd),
        .meta_dstaddr (meta_dstaddr),
        .meta_srcaddr (meta_srcaddr)
    );

    rx_payload_assembler u_payload (
        .ioclk         (ioclk),
        .ionreset      (ionreset),
        .beat_take     (beat_take),
        .first_beat    (first_beat),
        .csr_iowidth   (csr_iowidth),
        .byte_cnt      (byte_cnt),
        .payload_bytes (payload_bytes),
        .phy_rxdata    (phy_rxdata),
        .payload       (payload)
    );

    // Both ports carry the same fields and the valids select the owner
    assign req_cmd      = meta_cmd;
    assign req_dstaddr  = meta_dstaddr;
    assign req_srcaddr  = meta_srcaddr;
    assign req_data     = payload;
    assign resp_cmd     = meta_cmd;
    assign resp_dstaddr = meta_dstaddr;
    assign resp_srcaddr = meta_srcaddr;
    assign resp_data    = payload;

endmodule

//--- verif/tb_lumi_rx.sv
/*
 * Link receiver testbench
 * Directed packets at each bus width, checked on the request and
 * response ports, with back-pressure and input enable cases
 */

`timescale 1ns/1ps

`include "lumi_rx_settings.svh"

module tb_lumi_rx;

    localparam int TIMEOUT_CYCLES = 2000;   // Roughly 150 cycles of traffic plus margin

    logic                  ioclk;
    logic                  ionreset;
    logic                  csr_en;
    lumi_rx_pkg::iowidth_t csr_iowidth;
    lumi_rx_pkg::beat_t    phy_rxdata;
    logic                  phy_rxvld;
    logic                  phy_rxrdy;
    lumi_rx_pkg::cmd_t     req_cmd;
    lumi_rx_pkg::addr_t    req_dstaddr;
    lumi_rx_pkg::addr_t    req_srcaddr;
    lumi_rx_pkg::data_t    req_data;
    logic                  req_valid;
    logic                  req_ready;
    lumi_rx_pkg::cmd_t     resp_cmd;
    lumi_rx_pkg::addr_t    resp_dstaddr;
    lumi_rx_pkg::addr_t    resp_srcaddr;
    lumi_rx_pkg::data_t    resp_data;
    logic                  resp_valid;
    logic                  resp_ready;

    int                    seed;
    int                    cycle_cnt = 0;
    logic [7:0]            tx_bytes[$];     // Packet bytes in wire order
    lumi_rx_pkg::data_t    exp_data;
    lumi_rx_pkg::cmd_t     got_cmd;
    lumi_rx_pkg::addr_t    got_dst;
    lumi_rx_pkg::addr_t    got_src;
    lumi_rx_pkg::data_t    got_data;
    logic                  got_req;
    logic                  got_resp;

    lumi_rx_top DUT (.*);

    initial ioclk = 1'b0;
    always #20 ioclk = ~ioclk;

    always @(posedge ioclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    //##################################################
    // Failure reporting and compares
    //##################################################
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_cmd(input string test, input lumi_rx_pkg::cmd_t exp,
                             input lumi_rx_pkg::cmd_t act);
        if (act !== exp)
            abort_run($sformatf("error %s: expected %h actual %h", test, exp, act));
    endtask

    task automatic check_addr(input string test, input lumi_rx_pkg::addr_t exp,
                              input lumi_rx_pkg::addr_t act);
        if (act !== exp)
            abort_run($sformatf("error %s: expected %h actual %h", test, exp, act));
    endtask

    task automatic check_data(input string test, input lumi_rx_pkg::data_t exp,
                              input lumi_rx_pkg::data_t act);
        if (act !== exp)
            abort_run($sformatf("error %s: expected %h actual %h", test, exp, act));
    endtask

    task automatic check_bit(input string test, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("error %s: expected %b actual %b", test, exp, act));
    endtask

    //##################################################
    // Packet model
    //##################################################
    function automatic lumi_rx_pkg::cmd_t make_cmd(input lumi_rx_pkg::opcode_e op,
                                                   input int len, input int size);
        lumi_rx_pkg::cmd_t c;
        c.upper  = 16'($random(seed));     // Upper bits only pass through
        c.len    = 8'(len);
        c.size   = 3'(size);
        c.opcode = op;
        return c;
    endfunction

    function automatic lumi_rx_pkg::pkt_dest_e expected_dest(input lumi_rx_pkg::cmd_t c);
        case (c.opcode)
            lumi_rx_pkg::OP_REQ_READ, lumi_rx_pkg::OP_REQ_WRITE,
            lumi_rx_pkg::OP_REQ_POSTED, lumi_rx_pkg::OP_REQ_ATOMIC: return lumi_rx_pkg::DEST_REQ;
            lumi_rx_pkg::OP_RESP_READ, lumi_rx_pkg::OP_RESP_WRITE:  return lumi_rx_pkg::DEST_RESP;
            default:                                                return lumi_rx_pkg::DEST_DROP;
        endcase
    endfunction

    function automatic int payload_len(input lumi_rx_pkg::cmd_t c);
        int n;
        n = 0;
        if (expected_dest(c) != lumi_rx_pkg::DEST_DROP &&
            c.opcode != lumi_rx_pkg::OP_REQ_READ && c.opcode != lumi_rx_pkg::OP_RESP_WRITE) begin
            n = (int'(c.len) + 1) << c.size;
            if (n > `LUMI_DATA_BYTES)
                n = `LUMI_DATA_BYTES;
        end
        return n;
    endfunction

    function automatic lumi_rx_pkg::addr_t rand_addr();
        return {$random(seed), $random(seed)};
    endfunction

    // Fills tx_bytes and the expected payload word
    task automatic build_packet(input lumi_rx_pkg::cmd_t cmd, input lumi_rx_pkg::addr_t dst,
                                input lumi_rx_pkg::addr_t src);
        int         n;
        logic [7:0] b;
        n = payload_len(cmd);
        tx_bytes.delete();
        exp_data = '0;
        for (int i = 0; i < 4; i++)
            tx_bytes.push_back(cmd[i*8 +: 8]);
        if (expected_dest(cmd) != lumi_rx_pkg::DEST_DROP) begin
            for (int i = 0; i < 8; i++)
                tx_bytes.push_back(dst[i*8 +: 8]);
            for (int i = 0; i < 8; i++)
                tx_bytes.push_back(src[i*8 +: 8]);
            for (int i = 0; i < n; i++) begin
                b = 8'($random(seed));
                tx_bytes.push_back(b);
                exp_data[i*8 +: 8] = b;
            end
        end
    endtask

    //##################################################
    // PHY and output port drivers
    //##################################################
    task automatic drive_beat(input int b, input int w);
        int idx;
        phy_rxdata = {$random(seed), $random(seed)};   // Noise in lanes outside the packet
        for (int l = 0; l < w; l++) begin
            idx = b * w + l;
            if (idx < int'(tx_bytes.size()))
                phy_rxdata[l*8 +: 8] = tx_bytes[idx];
        end
        phy_rxvld = 1'b1;
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic send_packet(input lumi_rx_pkg::iowidth_t code);
        int w;
        int beats;
        bit taken;
        w = 1 << code;
        beats = (int'(tx_bytes.size()) + w - 1) / w;
        csr_iowidth = code;
        for (int b = 0; b < beats; b++) begin
            drive_beat(b, w);
            taken = 1'b0;
            while (!taken) begin
                @(negedge ioclk);
                taken = phy_rxrdy;      // Accepted at the coming edge
                @(posedge ioclk);
                #2;
            end
        end
        phy_rxvld  = 1'b0;
        phy_rxdata = '0;
    endtask

    task automatic take_output(input string test);
        @(negedge ioclk);
        if (!(req_valid || resp_valid))
            abort_run($sformatf("%s: no output valid in the cycle after the final beat", test));
        got_req  = req_valid;
        got_resp = resp_valid;
        got_cmd  = req_valid ? req_cmd : resp_cmd;
        got_dst  = req_valid ? req_dstaddr : resp_dstaddr;
        got_src  = req_valid ? req_srcaddr : resp_srcaddr;
        got_data = req_valid ? req_data : resp_data;
    endtask

    task automatic check_output(input string test, input lumi_rx_pkg::cmd_t cmd,
                                input lumi_rx_pkg::addr_t dst, input lumi_rx_pkg::addr_t src);
        lumi_rx_pkg::pkt_dest_e dest;
        dest = expected_dest(cmd);
        check_bit({test, " req_valid"}, dest == lumi_rx_pkg::DEST_REQ, got_req);
        check_bit({test, " resp_valid"}, dest == lumi_rx_pkg::DEST_RESP, got_resp);
        check_cmd({test, " cmd"}, cmd, got_cmd);
        check_addr({test, " dstaddr"}, dst, got_dst);
        check_addr({test, " srcaddr"}, src, got_src);
        check_data({test, " data"}, exp_data, got_data);
    endtask

    // Commit with ready high and see PHY ready return in ST_IDLE
    task automatic finish_transfer(input string test);
        @(posedge ioclk);
        #2;
        @(negedge ioclk);
        check_bit({test, " phy_rxrdy after commit"}, 1'b1, phy_rxrdy);
        check_bit({test, " valid after commit"}, 1'b0, req_valid | resp_valid);
        @(posedge ioclk);
        #2;
    endtask

    task automatic run_packet(input string test, input lumi_rx_pkg::iowidth_t code,
                              input lumi_rx_pkg::cmd_t cmd, input lumi_rx_pkg::addr_t dst,
                              input lumi_rx_pkg::addr_t src);
        build_packet(cmd, dst, src);
        send_packet(code);
        take_output(test);
        check_output(test, cmd, dst, src);
        finish_transfer(test);
    endtask

    //##################################################
    // Tests
    //##################################################
    task automatic test_posted_write();
        run_packet("posted_write_w8", 8'd3, make_cmd(lumi_rx_pkg::OP_REQ_POSTED, 7, 0),
                   rand_addr(), rand_addr());
    endtask

    task automatic test_no_payload();
        // Length field set but ignored for these opcodes
        run_packet("read_req_w2", 8'd1, make_cmd(lumi_rx_pkg::OP_REQ_READ, 3, 2),
                   rand_addr(), rand_addr());
        run_packet("write_resp_w4", 8'd2, make_cmd(lumi_rx_pkg::OP_RESP_WRITE, 0, 0),
                   rand_addr(), rand_addr());
    endtask

    task automatic test_read_resp_full();
        run_packet("read_resp_w4", 8'd2, make_cmd(lumi_rx_pkg::OP_RESP_READ, 7, 2),
                   rand_addr(), rand_addr());
    endtask

    task automatic test_link_drop();
        build_packet(make_cmd(lumi_rx_pkg::OP_LINK, 0, 0), '0, '0);
        send_packet(8'd3);
        repeat (4) begin
            @(negedge ioclk);
            check_bit("link_drop valid", 1'b0, req_valid | resp_valid);
            check_bit("link_drop phy_rxrdy", 1'b1, phy_rxrdy);
        end
        @(posedge ioclk);
        #2;
        run_packet("write_after_link", 8'd2, make_cmd(lumi_rx_pkg::OP_REQ_WRITE, 3, 0),
                   rand_addr(), rand_addr());
    endtask

    task automatic test_backpressure();
        lumi_rx_pkg::cmd_t  cmd;
        lumi_rx_pkg::addr_t dst;
        lumi_rx_pkg::addr_t src;
        int                 stall;
        cmd   = make_cmd(lumi_rx_pkg::OP_REQ_POSTED, 15, 0);
        dst   = rand_addr();
        src   = rand_addr();
        stall = 3 + int'({$random(seed)} % 8);      // 3 to 10 cycles
        req_ready = 1'b0;
        build_packet(cmd, dst, src);
        send_packet(8'd3);
        take_output("backpressure");
        check_output("backpressure", cmd, dst, src);
        repeat (stall) begin
            @(negedge ioclk);
            check_bit("backpressure hold valid", 1'b1, req_valid);
            check_bit("backpressure hold phy_rxrdy", 1'b0, phy_rxrdy);
            check_cmd("backpressure hold cmd", cmd, req_cmd);
            check_addr("backpressure hold dstaddr", dst, req_dstaddr);
            check_addr("backpressure hold srcaddr", src, req_srcaddr);
            check_data("backpressure hold data", exp_data, req_data);
        end
        @(posedge ioclk);
        #2;
        req_ready = 1'b1;
        finish_transfer("backpressure");
        run_packet("after_backpressure", 8'd1, make_cmd(lumi_rx_pkg::OP_REQ_ATOMIC, 1, 1),
                   rand_addr(), rand_addr());
    endtask

    task automatic test_enable_stall();
        lumi_rx_pkg::cmd_t  cmd;
        lumi_rx_pkg::addr_t dst;
        lumi_rx_pkg::addr_t src;
        cmd = make_cmd(lumi_rx_pkg::OP_REQ_ATOMIC, 63, 0);  // Payload clamps to 32
        dst = rand_addr();
        src = rand_addr();
        csr_en      = 1'b0;
        csr_iowidth = 8'd3;
        build_packet(cmd, dst, src);
        drive_beat(0, 8);
        repeat (20) begin
            @(negedge ioclk);
            check_bit("enable_stall phy_rxrdy", 1'b0, phy_rxrdy);
            check_bit("enable_stall valid", 1'b0, req_valid | resp_valid);
        end
        @(posedge ioclk);
        #2;
        csr_en = 1'b1;
        send_packet(8'd3);
        take_output("enable_stall");
        check_output("enable_stall", cmd, dst, src);
        finish_transfer("enable_stall");
    endtask

    initial begin
        seed        = 28576;
        ionreset    = 1'b0;
        csr_en      = 1'b1;
        csr_iowidth = 8'd3;
        phy_rxdata  = '0;
        phy_rxvld   = 1'b0;
        req_ready   = 1'b1;
        resp_ready  = 1'b1;
        repeat (10) @(posedge ioclk);
        #2;
        ionreset = 1'b1;
        @(negedge ioclk);
        check_bit("reset phy_rxrdy", 1'b0, phy_rxrdy);     // Held low one cycle
        check_bit("reset valid", 1'b0, req_valid | resp_valid);
        @(posedge ioclk);
        #2;

        test_posted_write();
        test_no_payload();
        test_read_resp_full();
        test_link_drop();
        test_backpressure();
        test_enable_stall();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/lumi_rx_pkg.sv
src/rx_header_decode.sv
src/rx_packet_fsm.sv
src/rx_metadata_assembler.sv
src/rx_payload_assembler.sv
src/lumi_rx_top.sv
verif/tb_lumi_rx.sv

//--- run.sh
#!/usr/bin/env bash
# Build the link receiver testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_lumi_rx -o tb_lumi_rx
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build did not complete"
    exit $status
fi

./obj_dir/tb_lumi_rx
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
